/* filelist.f */
+incdir+source
source/rv_isa_pkg.sv
source/id_ctrl_pkg.sv
source/id_decoder.sv
source/id_regfile.sv
source/id_branch_unit.sv
source/id_stage.sv
testbench/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  # rtl
  - include_dirs:
      - source
    files:
      - source/rv_isa_pkg.sv
      - source/id_ctrl_pkg.sv
      - source/id_decoder.sv
      - source/id_regfile.sv
      - source/id_branch_unit.sv
      - source/id_stage.sv
  # test
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_id_stage.sv

/* testbench/tb_id_stage.sv */
// decode stage testbench that drives fetch and writeback ports and checks with assertions
`include "id_settings.svh"

module tb_id_stage;
  timeunit 1ns;
  timeprecision 1ps;

  import rv_isa_pkg::*;
  import id_ctrl_pkg::*;

  localparam int CYCLE_LIMIT = 400;   // about twice the summed test lengths

  logic i_clk, i_reset, i_fs_valid, i_es_allowin, i_wb_wen;
  logic [31:0] i_fs_inst;
  logic [`XLEN-1:0] i_fs_pc, i_wb_data;
  logic [`GPR_IDX_W-1:0] i_wb_addr, i_es_rd, i_ms_rd, i_ws_rd;
  logic o_ds_allowin, o_ds_to_es_valid, o_gpr_wen, o_mem_ren, o_mem_wen, o_invalid, o_br_taken;
  logic [`XLEN-1:0] o_pc, o_rs1_data, o_rs2_data, o_imm, o_br_target;
  logic [`GPR_IDX_W-1:0] o_rd;
  alu_op_e o_alu_op;
  src1_sel_e o_alu_src1;
  src2_sel_e o_alu_src2;
  mem_op_e o_mem_op;

  int errors = 0, errs_at_start = 0, tests_run = 0, tests_failed = 0, cycles = 0;
  logic [31:0] lfsr = 32'h170a_5841;
  logic [`XLEN-1:0] mirror [`NUM_GPR];   // behavioral copy of the register file
  logic m_valid, m_ready, m_allowin;
  logic [31:0] m_inst;
  logic [5*`XLEN+21:0] out_now;

  // OP sweep with funct3, bit 30 and the expected alu op
  logic [2:0] op_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  logic op_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
  alu_op_e op_exp [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
                           ALU_SRA, ALU_OR, ALU_AND};
  logic [2:0] br_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

  id_stage DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic logic [4:0] nz_reg();
    logic [4:0] r;
    r = 5'(rand_bits(5));
    return (r == 5'd0) ? 5'd1 : r;
  endfunction

  function automatic logic [63:0] sext(input logic [63:0] v, input int w);
    return $signed(v << (64 - w)) >>> (64 - w);
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // conditional branch rule by funct3
  function automatic logic branch_cond(input logic [2:0] f3, input logic [63:0] a, b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic pending(input logic [4:0] rd, input logic [31:0] inst);
    return (rd != 5'd0) && (rd == inst[19:15] || rd == inst[24:20]);
  endfunction

  // reference of the stage register and handshake
  assign m_ready = !(pending(i_es_rd, m_inst) || pending(i_ms_rd, m_inst) ||
                     pending(i_ws_rd, m_inst));
  assign m_allowin = !m_valid || (m_ready && i_es_allowin);
  assign out_now = {o_pc, o_rs1_data, o_rs2_data, o_imm, o_rd, o_alu_op, o_alu_src1, o_alu_src2,
                    o_gpr_wen, o_mem_ren, o_mem_wen, o_mem_op, o_invalid, o_br_taken,
                    o_br_target, o_ds_to_es_valid};

  always @(posedge i_clk) begin
    if (i_reset) begin
      m_valid <= 1'b0;
      m_inst  <= '0;
      for (int k = 0; k < `NUM_GPR; k++) mirror[k] <= '0;
    end else begin
      if (m_allowin) m_valid <= i_fs_valid;
      if (m_allowin && i_fs_valid) m_inst <= i_fs_inst;
      if (i_wb_wen && i_wb_addr != 5'd0) mirror[i_wb_addr] <= i_wb_data;
    end
  end

  a_allowin: assert property (@(negedge i_clk) disable iff (i_reset) o_ds_allowin == m_allowin)
    else begin
      errors++;
      $display("FAILED at %0t ns: o_ds_allowin got %b expected %b", $time, o_ds_allowin, m_allowin);
    end

  a_to_es_valid: assert property (@(negedge i_clk) disable iff (i_reset)
    o_ds_to_es_valid == (m_valid && m_ready))
    else begin
      errors++;
      $display("FAILED at %0t ns: o_ds_to_es_valid got %b expected %b", $time,
               o_ds_to_es_valid, m_valid && m_ready);
    end

  a_stall: assert property (@(negedge i_clk) disable iff (i_reset)
    (m_valid && !m_ready) |-> (!o_br_taken && !o_ds_allowin))
    else begin
      errors++;
      $display("at %0t ns a stalled instruction redirected fetch or accepted a new one", $time);
    end

  a_hold: assert property (@(negedge i_clk) disable iff (i_reset)
    (m_valid && !i_es_allowin && $past(m_valid && !i_es_allowin) && !$past(i_wb_wen) &&
     $stable({i_es_rd, i_ms_rd, i_ws_rd})) |-> $stable(out_now))
    else begin
      errors++;
      $display("at %0t ns outputs changed while execute held the stage", $time);
    end

  task automatic expect_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // drive one word and return on its transfer edge
  task automatic send_inst(input logic [31:0] inst, input logic [63:0] pc);
    @(posedge i_clk);
    i_fs_valid <= 1'b1;
    i_fs_inst  <= inst;
    i_fs_pc    <= pc;
    @(negedge i_clk);
    while (!o_ds_allowin) @(negedge i_clk);
    @(posedge i_clk);
    i_fs_valid <= 1'b0;
  endtask

  task automatic wb_write(input logic [4:0] addr, input logic [63:0] data);
    @(posedge i_clk);
    i_wb_wen  <= 1'b1;
    i_wb_addr <= addr;
    i_wb_data <= data;
    @(posedge i_clk);
    i_wb_wen  <= 1'b0;
  endtask

  task automatic decode_matches(input logic [31:0] inst, input logic [63:0] imm, input alu_op_e op,
                                input src1_sel_e s1, input src2_sel_e s2,
                                input logic gwen, input logic mren, input logic mwen);
    expect_val("o_ds_to_es_valid", 64'(o_ds_to_es_valid), 64'd1);
    expect_val("o_rs1_data", o_rs1_data, mirror[inst[19:15]]);
    expect_val("o_rs2_data", o_rs2_data, mirror[inst[24:20]]);
    expect_val("o_rd", 64'(o_rd), 64'(inst[11:7]));
    expect_val("o_imm", o_imm, imm);
    expect_val("o_alu_op", 64'(o_alu_op), 64'(op));
    expect_val("o_alu_src1", 64'(o_alu_src1), 64'(s1));
    expect_val("o_alu_src2", 64'(o_alu_src2), 64'(s2));
    expect_val("o_gpr_wen", 64'(o_gpr_wen), 64'(gwen));
    expect_val("o_mem_ren", 64'(o_mem_ren), 64'(mren));
    expect_val("o_mem_wen", 64'(o_mem_wen), 64'(mwen));
    expect_val("o_invalid", 64'(o_invalid), 64'd0);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d failed checks", name, errors - errs_at_start);
    end
    errs_at_start = errors;
  endtask

  task automatic reset_state_check();
    for (int k = 0; k < 4; k++) begin
      if (k == 3) begin
        @(posedge i_clk);
        i_reset <= 1'b0;   // fourth reset edge
      end
      @(negedge i_clk);
      expect_val("o_ds_to_es_valid", 64'(o_ds_to_es_valid), 64'd0);
      expect_val("o_br_taken", 64'(o_br_taken), 64'd0);
      expect_val("o_ds_allowin", 64'(o_ds_allowin), 64'd1);
    end
  endtask

  task automatic decode_sweep();
    logic [31:0] inst;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [2:0]  f3;
    for (int k = 0; k < 12; k++) wb_write(nz_reg(), rand_bits(64));
    imm12 = 12'(rand_bits(12));
    inst = i_type(imm12, 5'(rand_bits(5)), 3'b000, nz_reg(), OPC_OP_IMM);
    send_inst(inst, rand_bits(64));
    @(negedge i_clk);
    decode_matches(inst, sext(64'(imm12), 12), ALU_ADD, SRC1_RS1, SRC2_IMM, 1'b1, 1'b0, 1'b0);
    for (int k = 0; k < 10; k++) begin
      inst = r_type({1'b0, op_alt[k], 5'b0}, 5'(rand_bits(5)), 5'(rand_bits(5)), op_f3[k],
                    nz_reg(), OPC_OP);
      send_inst(inst, rand_bits(64));
      @(negedge i_clk);
      decode_matches(inst, 64'd0, op_exp[k], SRC1_RS1, SRC2_RS2, 1'b1, 1'b0, 1'b0);
    end
    imm12 = 12'(rand_bits(12));
    f3 = 3'(rand_bits(3));
    if (f3 == 3'b111) f3 = 3'b011;   // ld
    inst = i_type(imm12, 5'(rand_bits(5)), f3, nz_reg(), OPC_LOAD);
    send_inst(inst, rand_bits(64));
    @(negedge i_clk);
    decode_matches(inst, sext(64'(imm12), 12), ALU_ADD, SRC1_RS1, SRC2_IMM, 1'b1, 1'b1, 1'b0);
    expect_val("o_mem_op", 64'(o_mem_op), 64'(f3));
    imm12 = 12'(rand_bits(12));
    f3 = {1'b0, 2'(rand_bits(2))};
    inst = s_type(imm12, 5'(rand_bits(5)), 5'(rand_bits(5)), f3);
    send_inst(inst, rand_bits(64));
    @(negedge i_clk);
    decode_matches(inst, sext(64'(imm12), 12), ALU_ADD, SRC1_RS1, SRC2_IMM, 1'b0, 1'b0, 1'b1);
    expect_val("o_mem_op", 64'(o_mem_op), 64'(f3));
    imm20 = 20'(rand_bits(20));
    inst = {imm20, nz_reg(), OPC_LUI};
    send_inst(inst, rand_bits(64));
    @(negedge i_clk);
    decode_matches(inst, sext(64'({imm20, 12'b0}), 32), ALU_COPY_B, SRC1_ZERO, SRC2_IMM,
                   1'b1, 1'b0, 1'b0);
    // system opcode lies outside the subset
    send_inst(i_type(12'h001, 5'd0, 3'b000, 5'd0, 7'b1110011), rand_bits(64));
    @(negedge i_clk);
    expect_val("o_invalid", 64'(o_invalid), 64'd1);
    expect_val("o_gpr_wen", 64'(o_gpr_wen), 64'd0);
    expect_val("o_mem_ren", 64'(o_mem_ren), 64'd0);
    expect_val("o_mem_wen", 64'(o_mem_wen), 64'd0);
  endtask

  task automatic zero_register_read();
    wb_write(5'd0, rand_bits(64) | 64'd1);
    send_inst(r_type(7'd0, 5'd0, 5'd0, 3'b000, 5'd5, OPC_OP), rand_bits(64));
    @(negedge i_clk);
    expect_val("o_rs1_data", o_rs1_data, 64'd0);
    expect_val("o_rs2_data", o_rs2_data, 64'd0);
  endtask

  task automatic stall_expected();
    @(negedge i_clk);
    expect_val("o_ds_to_es_valid", 64'(o_ds_to_es_valid), 64'd0);
    expect_val("o_ds_allowin", 64'(o_ds_allowin), 64'd0);
    expect_val("o_br_taken", 64'(o_br_taken), 64'd0);
  endtask

  task automatic interlock_stall();
    logic [4:0] a, b;
    a = nz_reg();
    b = (a == 5'd31) ? 5'd1 : a + 5'd1;
    wb_write(a, rand_bits(64));
    wb_write(b, rand_bits(64));
    send_inst(b_type(13'h010, b, a, 3'b001), rand_bits(64));   // bne
    i_es_rd <= a;
    i_ms_rd <= b;
    stall_expected();
    stall_expected();
    @(posedge i_clk);
    i_es_rd <= 5'd0;
    stall_expected();
    @(posedge i_clk);
    i_ms_rd <= 5'd0;
    i_ws_rd <= b;
    stall_expected();
    @(posedge i_clk);
    i_ws_rd <= 5'd0;
    @(negedge i_clk);
    while (!o_ds_to_es_valid) @(negedge i_clk);
    expect_val("o_br_taken", 64'(o_br_taken), 64'(mirror[a] != mirror[b]));
    // rd 0 in flight against x0 sources
    send_inst(r_type(7'd0, 5'd0, 5'd0, 3'b000, 5'd1, OPC_OP), rand_bits(64));
    @(negedge i_clk);
    expect_val("o_ds_to_es_valid", 64'(o_ds_to_es_valid), 64'd1);
  endtask

  task automatic back_pressure_hold();
    logic [5*`XLEN+21:0] snap;
    send_inst(i_type(12'(rand_bits(12)), nz_reg(), 3'b011, nz_reg(), OPC_LOAD), rand_bits(64));
    i_es_allowin <= 1'b0;
    i_fs_valid   <= 1'b1;            // next word waits at the input
    i_fs_inst    <= r_type(7'd0, nz_reg(), nz_reg(), 3'b000, nz_reg(), OPC_OP);
    @(negedge i_clk);
    snap = out_now;
    for (int k = 0; k < 4; k++) begin
      @(negedge i_clk);
      expect_val("o_ds_allowin", 64'(o_ds_allowin), 64'd0);
      assert (out_now === snap) else begin
        errors++;
        $display("at %0t ns decoded outputs moved under back-pressure", $time);
      end
    end
    @(posedge i_clk);
    i_es_allowin <= 1'b1;
    i_fs_valid   <= 1'b0;
  endtask

  task automatic redirect_sweep();
    logic [4:0]  a, b;
    logic [63:0] va, vb, pc;
    logic [12:0] imm13;
    logic [20:0] imm21;
    logic [11:0] imm12;
    logic [31:0] inst;
    for (int k = 0; k < 6; k++) begin
      a = nz_reg();
      b = (a == 5'd31) ? 5'd1 : a + 5'd1;
      va = rand_bits(64);
      vb = rand_bits(1) ? va : rand_bits(64);
      wb_write(a, va);
      wb_write(b, vb);
      imm13 = {12'(rand_bits(12)), 1'b0};
      pc = {62'(rand_bits(62)), 2'b00};
      send_inst(b_type(imm13, b, a, br_f3[k]), pc);
      @(negedge i_clk);
      expect_val("o_ds_to_es_valid", 64'(o_ds_to_es_valid), 64'd1);
      expect_val("o_pc", o_pc, pc);
      expect_val("o_br_taken", 64'(o_br_taken), 64'(branch_cond(br_f3[k], va, vb)));
      expect_val("o_br_target", o_br_target, pc + sext(64'(imm13), 13));
    end
    imm21 = {20'(rand_bits(20)), 1'b0};
    pc = {62'(rand_bits(62)), 2'b00};
    inst = j_type(imm21, nz_reg());
    send_inst(inst, pc);
    @(negedge i_clk);
    decode_matches(inst, sext(64'(imm21), 21), ALU_ADD, SRC1_PC, SRC2_FOUR, 1'b1, 1'b0, 1'b0);
    expect_val("o_br_taken", 64'(o_br_taken), 64'd1);
    expect_val("o_br_target", o_br_target, pc + sext(64'(imm21), 21));
    imm12 = 12'(rand_bits(12));
    a = nz_reg();
    inst = i_type(imm12, a, 3'b000, nz_reg(), OPC_JALR);
    send_inst(inst, rand_bits(64));
    @(negedge i_clk);
    decode_matches(inst, sext(64'(imm12), 12), ALU_ADD, SRC1_PC, SRC2_FOUR, 1'b1, 1'b0, 1'b0);
    expect_val("o_br_taken", 64'(o_br_taken), 64'd1);
    expect_val("o_br_target", o_br_target, (mirror[a] + sext(64'(imm12), 12)) & ~64'd1);
  endtask

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("run stopped after %0d cycles without finishing", cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    i_reset = 1'b1;
    i_fs_valid = 1'b0;
    i_fs_inst = '0;
    i_fs_pc = '0;
    i_es_allowin = 1'b1;
    i_wb_wen = 1'b0;
    i_wb_addr = '0;
    i_wb_data = '0;
    i_es_rd = '0;
    i_ms_rd = '0;
    i_ws_rd = '0;
    reset_state_check();
    report_test("reset_state");
    decode_sweep();
    report_test("read_and_decode");
    zero_register_read();
    report_test("register_zero");
    interlock_stall();
    report_test("interlock");
    back_pressure_hold();
    report_test("back_pressure");
    redirect_sweep();
    report_test("redirect");
    repeat (2) @(negedge i_clk);
    $display("tests run %0d, tests failed %0d, failed checks %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* source/id_stage.sv */
// instruction decode stage top: stage register, handshake, RAW interlock and redirect
`include "id_settings.svh"

module id_stage (
  input  logic                   i_clk,
  input  logic                   i_reset,
  // from fetch
  input  logic                   i_fs_valid,
  input  logic [31:0]            i_fs_inst,
  input  logic [`XLEN-1:0]       i_fs_pc,
  // handshake
  output logic                   o_ds_allowin,
  input  logic                   i_es_allowin,
  output logic                   o_ds_to_es_valid,
  // to execute
  output logic [`XLEN-1:0]       o_pc,
  output logic [`XLEN-1:0]       o_rs1_data,
  output logic [`XLEN-1:0]       o_rs2_data,
  output logic [`XLEN-1:0]       o_imm,
  output logic [`GPR_IDX_W-1:0]  o_rd,
  output id_ctrl_pkg::alu_op_e   o_alu_op,
  output id_ctrl_pkg::src1_sel_e o_alu_src1,
  output id_ctrl_pkg::src2_sel_e o_alu_src2,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output id_ctrl_pkg::mem_op_e   o_mem_op,
  output logic                   o_invalid,
  // redirect to fetch
  output logic                   o_br_taken,
  output logic [`XLEN-1:0]       o_br_target,
  // from writeback
  input  logic                   i_wb_wen,
  input  logic [`GPR_IDX_W-1:0]  i_wb_addr,
  input  logic [`XLEN-1:0]       i_wb_data,
  // destinations still in flight
  input  logic [`GPR_IDX_W-1:0]  i_es_rd,
  input  logic [`GPR_IDX_W-1:0]  i_ms_rd,
  input  logic [`GPR_IDX_W-1:0]  i_ws_rd
);

  import rv_isa_pkg::*;

  logic                  ds_valid;
  rv_inst_u              ds_inst;
  logic [`XLEN-1:0]      ds_pc;
  logic                  ready_go;
  logic [`GPR_IDX_W-1:0] rs1, rs2;
  logic                  is_jal, is_jalr, is_branch;
  br_funct_e             br_funct;
  logic                  br_taken;

  // pending write to a source register, x0 excluded
  function automatic logic raw_hit(input logic [`GPR_IDX_W-1:0] rd,
                                   input logic [`GPR_IDX_W-1:0] src1,
                                   input logic [`GPR_IDX_W-1:0] src2);
    return (rd != '0) && (rd == src1 || rd == src2);
  endfunction

  assign ready_go = !(raw_hit(i_es_rd, rs1, rs2) ||
                      raw_hit(i_ms_rd, rs1, rs2) ||
                      raw_hit(i_ws_rd, rs1, rs2));

  assign o_ds_allowin     = !ds_valid || (ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ready_go;

  // stage register
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
      ds_inst  <= '0;
      ds_pc    <= '0;
    end else begin
      if (o_ds_allowin) ds_valid <= i_fs_valid;
      if (i_fs_valid && o_ds_allowin) begin
        ds_inst <= i_fs_inst;
        ds_pc   <= i_fs_pc;
      end
    end
  end

  assign o_pc = ds_pc;

  id_decoder u_decoder (
    .i_inst      (ds_inst),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (o_rd),
    .o_imm       (o_imm),
    .o_alu_op    (o_alu_op),
    .o_alu_src1  (o_alu_src1),
    .o_alu_src2  (o_alu_src2),
    .o_gpr_wen   (o_gpr_wen),
    .o_mem_ren   (o_mem_ren),
    .o_mem_wen   (o_mem_wen),
    .o_mem_op    (o_mem_op),
    .o_is_jal    (is_jal),
    .o_is_jalr   (is_jalr),
    .o_is_branch (is_branch),
    .o_br_funct  (br_funct),
    .o_invalid   (o_invalid)
  );

  id_regfile u_regfile (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_raddr1 (rs1),
    .o_rdata1 (o_rs1_data),
    .i_raddr2 (rs2),
    .o_rdata2 (o_rs2_data),
    .i_wen    (i_wb_wen),
    .i_waddr  (i_wb_addr),
    .i_wdata  (i_wb_data)
  );

  id_branch_unit u_branch_unit (
    .i_pc        (ds_pc),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_imm       (o_imm),
    .i_is_jal    (is_jal),
    .i_is_jalr   (is_jalr),
    .i_is_branch (is_branch),
    .i_br_funct  (br_funct),
    .o_taken     (br_taken),
    .o_target    (o_br_target)
  );

  // redirect only once the operands are settled
  assign o_br_taken = ds_valid && ready_go && br_taken;

endmodule

/* source/id_branch_unit.sv */
// branch and jump resolution in the decode stage, drives the redirect to fetch
`include "id_settings.svh"

module id_branch_unit (
  input  logic [`XLEN-1:0]      i_pc,
  input  logic [`XLEN-1:0]      i_rs1_data,
  input  logic [`XLEN-1:0]      i_rs2_data,
  input  logic [`XLEN-1:0]      i_imm,
  input  logic                  i_is_jal,
  input  logic                  i_is_jalr,
  input  logic                  i_is_branch,
  input  rv_isa_pkg::br_funct_e i_br_funct,
  output logic                  o_taken,
  output logic [`XLEN-1:0]      o_target
);

  import rv_isa_pkg::*;

  logic             cond;
  logic [`XLEN-1:0] jalr_sum;

  always_comb begin
    case (i_br_funct)
      BR_BEQ:  cond = (i_rs1_data == i_rs2_data);
      BR_BNE:  cond = (i_rs1_data != i_rs2_data);
      BR_BLT:  cond = ($signed(i_rs1_data) <  $signed(i_rs2_data));
      BR_BGE:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      BR_BLTU: cond = (i_rs1_data <  i_rs2_data);
      BR_BGEU: cond = (i_rs1_data >= i_rs2_data);
      default: cond = 1'b0;    // reserved funct3 never branches
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;

  // jumps always taken
  assign o_taken = i_is_jal || i_is_jalr || (i_is_branch && cond);

  assign o_target = i_is_jalr ? {jalr_sum[`XLEN-1:1], 1'b0}
                              : i_pc + i_imm;

endmodule

/* source/id_regfile.sv */
// general register file of the decode stage, two async read ports and one write port
`include "id_settings.svh"

module id_regfile (
  input  logic                  i_clk,
  input  logic                  i_reset,
  // read ports
  input  logic [`GPR_IDX_W-1:0] i_raddr1,
  input  logic [`GPR_IDX_W-1:0] i_raddr2,
  output logic [`XLEN-1:0]      o_rdata1,
  output logic [`XLEN-1:0]      o_rdata2,
  // write port from writeback
  input  logic                  i_wen,
  input  logic [`GPR_IDX_W-1:0] i_waddr,
  input  logic [`XLEN-1:0]      i_wdata
);

  logic [`XLEN-1:0] regs [`NUM_GPR];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < `NUM_GPR; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin   // x0 stays zero
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, the stage interlock covers pending writes
  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

endmodule

/* source/id_decoder.sv */
// combinational instruction decoder, instantiated by the decode stage top
`include "id_settings.svh"

module id_decoder (
  input  rv_isa_pkg::rv_inst_u   i_inst,
  output logic [`GPR_IDX_W-1:0]  o_rs1,
  output logic [`GPR_IDX_W-1:0]  o_rs2,
  output logic [`GPR_IDX_W-1:0]  o_rd,
  output logic [`XLEN-1:0]       o_imm,
  output id_ctrl_pkg::alu_op_e   o_alu_op,
  output id_ctrl_pkg::src1_sel_e o_alu_src1,
  output id_ctrl_pkg::src2_sel_e o_alu_src2,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output id_ctrl_pkg::mem_op_e   o_mem_op,
  output logic                   o_is_jal,
  output logic                   o_is_jalr,
  output logic                   o_is_branch,
  output rv_isa_pkg::br_funct_e  o_br_funct,
  output logic                   o_invalid
);

  import rv_isa_pkg::*;
  import id_ctrl_pkg::*;

  logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [2:0]       funct3;
  logic             alt;            // bit 30, sub/sra select

  // funct3 to alu op, reg_op enables sub
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt_bit,
                                      input logic reg_op);
    alu_op_e op;
    case (f3)
      3'b000:  op = (alt_bit && reg_op) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt_bit ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign o_rs1  = i_inst.r_fmt.rs1;
  assign o_rs2  = i_inst.r_fmt.rs2;
  assign o_rd   = i_inst.r_fmt.rd;
  assign funct3 = i_inst.r_fmt.funct3;
  assign alt    = i_inst.r_fmt.funct7[5];

  assign o_mem_op   = mem_op_e'(funct3);
  assign o_br_funct = br_funct_e'(funct3);

  // immediates, each from its own format
  assign imm_i = {{(`XLEN-12){i_inst.i_fmt.imm_11_0[11]}}, i_inst.i_fmt.imm_11_0};
  assign imm_s = {{(`XLEN-12){i_inst.s_fmt.imm_11_5[6]}}, i_inst.s_fmt.imm_11_5,
                  i_inst.s_fmt.imm_4_0};
  assign imm_b = {{(`XLEN-13){i_inst.b_fmt.imm_12}}, i_inst.b_fmt.imm_12,
                  i_inst.b_fmt.imm_11, i_inst.b_fmt.imm_10_5, i_inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {{(`XLEN-32){i_inst.u_fmt.imm_31_12[19]}}, i_inst.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{(`XLEN-21){i_inst.j_fmt.imm_20}}, i_inst.j_fmt.imm_20,
                  i_inst.j_fmt.imm_19_12, i_inst.j_fmt.imm_11, i_inst.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    o_imm       = '0;
    o_alu_op    = ALU_ADD;
    o_alu_src1  = SRC1_RS1;
    o_alu_src2  = SRC2_RS2;
    o_gpr_wen   = 1'b0;
    o_mem_ren   = 1'b0;
    o_mem_wen   = 1'b0;
    o_is_jal    = 1'b0;
    o_is_jalr   = 1'b0;
    o_is_branch = 1'b0;
    o_invalid   = 1'b0;
    case (i_inst.r_fmt.opcode)
      OPC_LUI: begin
        o_imm      = imm_u;
        o_alu_op   = ALU_COPY_B;
        o_alu_src1 = SRC1_ZERO;
        o_alu_src2 = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm      = imm_u;
        o_alu_src1 = SRC1_PC;
        o_alu_src2 = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OPC_JAL: begin
        o_imm      = imm_j;
        o_alu_src1 = SRC1_PC;     // link = pc + 4
        o_alu_src2 = SRC2_FOUR;
        o_gpr_wen  = 1'b1;
        o_is_jal   = 1'b1;
      end
      OPC_JALR: begin
        o_imm      = imm_i;
        o_alu_src1 = SRC1_PC;
        o_alu_src2 = SRC2_FOUR;
        o_gpr_wen  = 1'b1;
        o_is_jalr  = 1'b1;
      end
      OPC_BRANCH: begin
        o_imm       = imm_b;
        o_is_branch = 1'b1;       // resolved in this stage
      end
      OPC_LOAD: begin
        o_imm      = imm_i;
        o_alu_src2 = SRC2_IMM;
        o_gpr_wen  = 1'b1;
        o_mem_ren  = 1'b1;
      end
      OPC_STORE: begin
        o_imm      = imm_s;
        o_alu_src2 = SRC2_IMM;
        o_mem_wen  = 1'b1;
      end
      OPC_OP_IMM: begin
        o_imm      = imm_i;
        o_alu_op   = alu_sel(funct3, alt, 1'b0);
        o_alu_src2 = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OPC_OP: begin
        o_alu_op  = alu_sel(funct3, alt, 1'b1);
        o_gpr_wen = 1'b1;
      end
      default: o_invalid = 1'b1;
    endcase
  end

endmodule

/* source/id_ctrl_pkg.sv */
// control types the decode stage hands to execute, shared by decoder, stage top and testbench
package id_ctrl_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_COPY_B    // result is operand B, for lui
  } alu_op_e;

  // operand A source
  typedef enum logic [1:0] {
    SRC1_RS1,
    SRC1_PC,
    SRC1_ZERO
  } src1_sel_e;

  // operand B source
  typedef enum logic [1:0] {
    SRC2_RS2,
    SRC2_IMM,
    SRC2_FOUR
  } src2_sel_e;

  // load/store width and sign, encoded as funct3
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_D  = 3'b011,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101,
    MEM_WU = 3'b110
  } mem_op_e;

endpackage

/* source/rv_isa_pkg.sv */
// RISC-V encoding package with opcodes, branch codes and the instruction formats
package rv_isa_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // funct3 of the conditional branches
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_funct_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one 32-bit word, six views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } rv_inst_u;

endpackage

/* source/id_settings.svh */
// width macros for the decode stage, included by every RTL file that sizes a port
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// data path and pc width
`define XLEN 64

// general register file
`define NUM_GPR   32
`define GPR_IDX_W 5

`endif
